//--- sim/cnn_patterns.hex
// Config: WIDTH_HEIGHT, DELAY_PARAMS, LAYER_CONFIG (ReLU, shifts 0/7)
// Then 16 pixels, 16 ReLU words, linear LAYER_CONFIG, 16 linear words
00040004
00003005
0000E000
// Pixels, raster order
00000002
00000002
00000002
00000002
00000002
00000002
00000002
00000002
00000002
00000002
00000002
00000002
00000002
00000002
00000002
00000002
// ReLU outputs {ch3, ch2, ch1, ch0}
FFFFD900
7EFFBF00
7EFFBF00
06FF1A00
00FF1500
00FF6A00
00FF6A00
00FF1000
00FF1500
00FF6A00
00FF6A00
00FF1000
00FF0000
00FF0000
00FF0000
00FF0000
// Linear LAYER_CONFIG
0000E008
// Linear outputs {ch3, ch2, ch1, ch0}
7F7F7F80
7E7F7FD3
7E7F7FD3
067F1A80
D97F1580
BC7F6A80
BC7F6A80
807F1080
D97F1580
BC7F6A80
BC7F6A80
807F1080
C67F8080
807FD380
807FD380
807F8580

//--- verilog.f
logic/cnn_accel_pkg.sv
logic/ahb_cfg_regs.sv
logic/frame_scan_ctrl.sv
logic/feature_window.sv
logic/conv_channel.sv
logic/cnn_accel.sv
sim/tb_cnn_accel.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -Wno-fatal --top-module tb_cnn_accel -f verilog.f -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	echo "Simulation failed"
	exit 1
fi

echo "Simulation passed"
exit 0

//--- sim/tb_cnn_accel.sv
`timescale 1ns/10ps
module tb_cnn_accel;

	localparam int N_PIX   = 16;
	localparam int TIMEOUT = 2000;  // Cycles per wait loop

	// Word offsets in the pattern file
	localparam int P_CFG  = 0;   // WIDTH_HEIGHT, DELAY_PARAMS, LAYER_CONFIG
	localparam int P_PIX  = 3;
	localparam int P_RELU = 19;
	localparam int P_LCFG = 35;  // Linear LAYER_CONFIG
	localparam int P_LIN  = 36;
	localparam int P_LEN  = 52;

	// Field masks from the register map
	localparam cnn_accel_pkg::ahb_data_t MASK_WH   = 32'h0fff_0fff;
	localparam cnn_accel_pkg::ahb_data_t MASK_DLY  = 32'h00ff_ffff;
	localparam cnn_accel_pkg::ahb_data_t MASK_LCFG = 32'h0000_ff08;

	// Reset defaults of a 4x4 ReLU frame with delays 200/160 and shifts 9/7
	localparam cnn_accel_pkg::ahb_data_t DEF_WH   = 32'h0004_0004;
	localparam cnn_accel_pkg::ahb_data_t DEF_DLY  = (32'd160 << 12) | 32'd200;
	localparam cnn_accel_pkg::ahb_data_t DEF_LCFG = (32'd7 << 13) | (32'd9 << 8);
	localparam cnn_accel_pkg::ahb_data_t ALT_WH   = 32'h0123_0765;  // Geometry unlike the default

	logic                     HCLK;
	logic                     HRESETn;
	logic                     hsel_i;
	logic                     hready_i;
	cnn_accel_pkg::htrans_t   htrans_i;
	logic                     hwrite_i;
	cnn_accel_pkg::ahb_addr_t haddr_i;
	cnn_accel_pkg::ahb_data_t hwdata_i;
	logic                     hready_o;
	logic                     hresp_o;
	cnn_accel_pkg::ahb_data_t hrdata_o;
	logic [31:0]              out_pixel_o;
	logic                     out_valid_o;

	logic [31:0] pat [0:P_LEN-1];
	logic [31:0] out_q [$];  // Outputs seen in the current frame
	int          errors;
	int          checks;
	int          cyc;
	int          err0;
	bit          timed_out;  // A wait loop ran out, later tests skipped
	cnn_accel_pkg::ahb_data_t rd;

	cnn_accel #(.IMG_WIDTH(4), .IMG_HEIGHT(4)) uut (.*);

	initial begin
		HCLK = 1'b0;
		forever #2 HCLK = ~HCLK;
	end

	always @(posedge HCLK) cyc <= cyc + 1;

	// ------------------------------
	// Output capture and bus status
	// ------------------------------
	always @(posedge HCLK) begin
		if (HRESETn) begin
			if (out_valid_o) out_q.push_back(out_pixel_o);
			if (hready_o !== 1'b1 || hresp_o !== 1'b0) begin
				$display("ERROR hready_o/hresp_o = 0x%h/0x%h, expected 0x1/0x0", hready_o, hresp_o);
				errors++;
			end
		end
	end

	task automatic ahb_write(input cnn_accel_pkg::reg_sel_t sel, input int pix,
		input cnn_accel_pkg::ahb_data_t data);
		@(posedge HCLK);  // Address phase
		hsel_i   <= 1'b1;
		htrans_i <= cnn_accel_pkg::TRANS_NONSEQ;
		hwrite_i <= 1'b1;
		haddr_i  <= (cnn_accel_pkg::ahb_addr_t'(pix) << 5) | (cnn_accel_pkg::ahb_addr_t'(sel) << 2);
		@(posedge HCLK);  // Data phase
		hsel_i   <= 1'b0;
		htrans_i <= 2'b00;
		hwrite_i <= 1'b0;
		hwdata_i <= data;
		@(posedge HCLK);  // Write lands here
	endtask

	task automatic ahb_read(input cnn_accel_pkg::reg_sel_t sel,
		output cnn_accel_pkg::ahb_data_t data);
		@(posedge HCLK);
		hsel_i   <= 1'b1;
		htrans_i <= cnn_accel_pkg::TRANS_NONSEQ;
		hwrite_i <= 1'b0;
		haddr_i  <= cnn_accel_pkg::ahb_addr_t'(sel) << 2;
		@(posedge HCLK);
		hsel_i   <= 1'b0;
		htrans_i <= 2'b00;
		@(negedge HCLK);  // Mid data phase
		data = hrdata_o;
	endtask

	task automatic check_word(input string name, input cnn_accel_pkg::ahb_data_t got,
		input cnn_accel_pkg::ahb_data_t exp);
		checks++;
		if (got !== exp) begin
			$display("ERROR %s = 0x%08h, expected 0x%08h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_pixel(input int idx, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("ERROR out_pixel_o[%0d] = 0x%08h, expected 0x%08h", idx, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			$display("ERROR %s = 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		errors++;
		timed_out = 1'b1;
	endtask

	task automatic report_test(input int num, input string name, input int err_before);
		$display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "failed");
	endtask

	// ------------------------------
	// One frame from start to done
	// ------------------------------
	task automatic run_frame(input int exp_base, input bit restart);
		int                       t0;
		bit                       done;
		cnn_accel_pkg::ahb_data_t d;
		out_q.delete();
		ahb_write(cnn_accel_pkg::REG_LAYER_START, 0, 32'h1);
		ahb_read(cnn_accel_pkg::REG_LAYER_DONE, d);
		check_word("LAYER_DONE after start", d, 32'h0);
		if (restart) begin  // Second start while the frame runs
			t0 = cyc;
			while (out_q.size() == 0 && cyc - t0 <= TIMEOUT) @(negedge HCLK);
			if (out_q.size() == 0) report_timeout("no output before the mid-frame start");
			else ahb_write(cnn_accel_pkg::REG_LAYER_START, 0, 32'h1);
		end
		if (!timed_out) begin
			t0   = cyc;
			done = 1'b0;
			while (!done && cyc - t0 <= TIMEOUT) begin
				ahb_read(cnn_accel_pkg::REG_LAYER_DONE, d);
				done = d[0];
			end
			if (!done) report_timeout("LAYER_DONE never went high");
			else begin
				check_count("outputs at LAYER_DONE", out_q.size(), N_PIX);
				repeat (20) @(posedge HCLK);  // No stray pulses after done
				check_count("outputs after frame", out_q.size(), N_PIX);
				for (int i = 0; i < N_PIX; i++) begin
					check_pixel(i, (i < out_q.size()) ? out_q[i] : 32'hx, pat[exp_base+i]);
				end
			end
		end
	endtask

	initial begin
		errors    = 0;
		checks    = 0;
		cyc       = 0;
		timed_out = 1'b0;
		HRESETn  <= 1'b0;
		hsel_i   <= 1'b0;
		hready_i <= 1'b1;
		htrans_i <= 2'b00;
		hwrite_i <= 1'b0;
		haddr_i  <= '0;
		hwdata_i <= '0;
		$readmemh("sim/cnn_patterns.hex", pat);
		repeat (4) @(posedge HCLK);
		HRESETn <= 1'b1;
		if (pat[P_LEN-1] === 32'hx) begin
			$display("Pattern file sim/cnn_patterns.hex is missing or short");
			errors++;
		end else begin
			// Reset defaults and read-back of written fields
			err0 = errors;
			ahb_read(cnn_accel_pkg::REG_WIDTH_HEIGHT, rd);
			check_word("WIDTH_HEIGHT reset", rd, DEF_WH);
			ahb_read(cnn_accel_pkg::REG_DELAY_PARAMS, rd);
			check_word("DELAY_PARAMS reset", rd, DEF_DLY);
			ahb_read(cnn_accel_pkg::REG_LAYER_CONFIG, rd);
			check_word("LAYER_CONFIG reset", rd, DEF_LCFG);
			ahb_read(cnn_accel_pkg::REG_LAYER_DONE, rd);
			check_word("LAYER_DONE reset", rd, 32'h0);
			ahb_read(3'd6, rd);
			check_word("unmapped index 6", rd, 32'h0);
			ahb_read(3'd7, rd);
			check_word("unmapped index 7", rd, 32'h0);
			ahb_write(cnn_accel_pkg::REG_WIDTH_HEIGHT, 0, ALT_WH | ~MASK_WH);
			ahb_read(cnn_accel_pkg::REG_WIDTH_HEIGHT, rd);
			check_word("WIDTH_HEIGHT other geometry", rd, ALT_WH);
			ahb_write(cnn_accel_pkg::REG_WIDTH_HEIGHT, 0, pat[P_CFG] | ~MASK_WH);
			ahb_read(cnn_accel_pkg::REG_WIDTH_HEIGHT, rd);
			check_word("WIDTH_HEIGHT", rd, pat[P_CFG]);
			ahb_write(cnn_accel_pkg::REG_DELAY_PARAMS, 0, pat[P_CFG+1] | ~MASK_DLY);
			ahb_read(cnn_accel_pkg::REG_DELAY_PARAMS, rd);
			check_word("DELAY_PARAMS", rd, pat[P_CFG+1]);
			ahb_write(cnn_accel_pkg::REG_LAYER_CONFIG, 0, pat[P_CFG+2] | ~MASK_LCFG);
			ahb_read(cnn_accel_pkg::REG_LAYER_CONFIG, rd);
			check_word("LAYER_CONFIG", rd, pat[P_CFG+2]);
			report_test(1, "register defaults and read-back", err0);

			err0 = errors;
			for (int i = 0; i < N_PIX; i++) begin
				ahb_write(cnn_accel_pkg::REG_INPUT_IMAGE, i, pat[P_PIX+i]);
			end
			run_frame(P_RELU, 1'b0);
			report_test(2, "ReLU frame and done flag", err0);

			if (!timed_out) begin
				err0 = errors;
				ahb_write(cnn_accel_pkg::REG_LAYER_CONFIG, 0, pat[P_LCFG]);
				ahb_read(cnn_accel_pkg::REG_LAYER_CONFIG, rd);
				check_word("LAYER_CONFIG linear", rd, pat[P_LCFG]);
				run_frame(P_LIN, 1'b0);
				report_test(3, "linear frame", err0);
			end

			if (!timed_out) begin
				err0 = errors;
				run_frame(P_LIN, 1'b1);
				report_test(4, "start during a running frame", err0);
			end
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) $display("*** PASSED ***");
		else $display("*** FAILED ***");
		$finish;
	end

endmodule

//--- logic/cnn_accel.sv
`timescale 1ns/10ps
module cnn_accel #(
	parameter int IMG_WIDTH  = 4,
	parameter int IMG_HEIGHT = 4
) (
	input  logic                     HCLK,
	input  logic                     HRESETn,
	input  logic                     hsel_i,
	input  logic                     hready_i,
	input  cnn_accel_pkg::htrans_t   htrans_i,
	input  logic                     hwrite_i,
	input  cnn_accel_pkg::ahb_addr_t haddr_i,
	input  cnn_accel_pkg::ahb_data_t hwdata_i,
	output logic                     hready_o,
	output logic                     hresp_o,
	output cnn_accel_pkg::ahb_data_t hrdata_o,
	output logic [31:0]              out_pixel_o,
	output logic                     out_valid_o
);
	cnn_accel_pkg::layer_cfg_t                   cfg;
	cnn_accel_pkg::pix_wr_t                      pix_wr;
	cnn_accel_pkg::window_t                      window;
	cnn_accel_pkg::dim_t                         row;
	cnn_accel_pkg::dim_t                         col;
	logic                                        start;
	logic                                        data_run;
	logic                                        frame_done;
	cnn_accel_pkg::act_t [cnn_accel_pkg::N_CH-1:0] ch_act;  // Channel 0 in low byte
	logic [cnn_accel_pkg::N_CH-1:0]              ch_vld;

	ahb_cfg_regs #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) u_regs (
		.HCLK, .HRESETn, .hsel_i, .hready_i, .htrans_i, .hwrite_i, .haddr_i, .hwdata_i,
		.hready_o, .hresp_o, .hrdata_o,
		.frame_done_i (frame_done),
		.cfg_o        (cfg),
		.pix_wr_o     (pix_wr),
		.start_o      (start)
	);

	frame_scan_ctrl u_scan (
		.HCLK, .HRESETn,
		.start_i      (start),
		.cfg_i        (cfg),
		.data_run_o   (data_run),
		.row_o        (row),
		.col_o        (col),
		.frame_done_o (frame_done)
	);

	feature_window #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) u_window (
		.HCLK, .HRESETn,
		.pix_wr_i   (pix_wr),
		.data_run_i (data_run),
		.row_i      (row),
		.col_i      (col),
		.cfg_i      (cfg),
		.window_o   (window)
	);

	// ------------------------------
	// Four channels, same window
	// ------------------------------
	for (genvar g = 0; g < cnn_accel_pkg::N_CH; g++) begin : g_ch
		conv_channel u_ch (
			.HCLK, .HRESETn,
			.window_i  (window),
			.weights_i (cnn_accel_pkg::CH_WEIGHTS[g]),
			.scale_i   (cnn_accel_pkg::CH_SCALE[g]),
			.bias_i    (cnn_accel_pkg::CH_BIAS[g]),
			.cfg_i     (cfg),
			.act_o     (ch_act[g]),
			.valid_o   (ch_vld[g])
		);
	end

	assign out_pixel_o = ch_act;
	assign out_valid_o = ch_vld[0];  // All channels in lockstep

endmodule

//--- logic/conv_channel.sv
`timescale 1ns/10ps
module conv_channel (
	input  logic                      HCLK,
	input  logic                      HRESETn,
	input  cnn_accel_pkg::window_t    window_i,
	input  cnn_accel_pkg::kernel_t    weights_i,
	input  cnn_accel_pkg::param_t     scale_i,
	input  cnn_accel_pkg::param_t     bias_i,
	input  cnn_accel_pkg::layer_cfg_t cfg_i,
	output cnn_accel_pkg::act_t       act_o,
	output logic                      valid_o
);
	typedef logic signed [16:0] prod_t;  // 9-bit signed pixel times weight
	typedef logic signed [47:0] wide_t;  // Scaled sum, room for bias << 31

	prod_t                 prod_q [cnn_accel_pkg::N_TAPS];
	cnn_accel_pkg::acc_t   acc_sum;
	cnn_accel_pkg::acc_t   acc_q;
	wide_t                 scaled_q;
	wide_t                 biased;
	wide_t                 shifted;
	logic [5:0]            shamt;     // bias_shift + act_shift, up to 38
	cnn_accel_pkg::act_t   act_nxt;
	cnn_accel_pkg::act_t   act_q;
	logic [3:0]            vld_q;     // One valid per stage

	// ------------------------------
	// Stage 1, products
	// ------------------------------
	always_ff @(posedge HCLK) begin
		for (int i = 0; i < cnn_accel_pkg::N_TAPS; i++) begin
			prod_q[i] <= $signed({1'b0, window_i.taps[i]}) * $signed(weights_i[i]);
		end
	end

	// Stage 2, adder tree
	always_comb begin
		acc_sum = '0;
		for (int i = 0; i < cnn_accel_pkg::N_TAPS; i++) begin
			acc_sum = acc_sum + cnn_accel_pkg::acc_t'(prod_q[i]);
		end
	end

	always_ff @(posedge HCLK) begin
		acc_q    <= acc_sum;
		scaled_q <= wide_t'(acc_q) * wide_t'(scale_i);  // Stage 3
		act_q    <= act_nxt;                            // Stage 4
	end

	// ------------------------------
	// Stage 4, bias, shift, activation
	// ------------------------------
	assign shamt   = {1'b0, cfg_i.bias_shift} + 6'(cfg_i.act_shift);
	assign biased  = scaled_q + (wide_t'(bias_i) <<< cfg_i.bias_shift);
	assign shifted = biased >>> shamt;

	always_comb begin
		if (cfg_i.act_type) begin  // Linear, signed byte
			if (shifted > 127) act_nxt = 8'h7f;
			else if (shifted < -128) act_nxt = 8'h80;
			else act_nxt = shifted[7:0];
		end else begin             // ReLU, clipped at 255
			if (shifted < 0) act_nxt = 8'h00;
			else if (shifted > 255) act_nxt = 8'hff;
			else act_nxt = shifted[7:0];
		end
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) vld_q <= '0;
		else vld_q <= {vld_q[2:0], window_i.valid};
	end

	assign act_o   = act_q;
	assign valid_o = vld_q[3];  // Four cycles after window valid

endmodule

//--- logic/feature_window.sv
`timescale 1ns/10ps
module feature_window #(
	parameter int IMG_WIDTH  = 4,
	parameter int IMG_HEIGHT = 4
) (
	input  logic                      HCLK,
	input  logic                      HRESETn,
	input  cnn_accel_pkg::pix_wr_t    pix_wr_i,
	input  logic                      data_run_i,
	input  cnn_accel_pkg::dim_t       row_i,
	input  cnn_accel_pkg::dim_t       col_i,
	input  cnn_accel_pkg::layer_cfg_t cfg_i,
	output cnn_accel_pkg::window_t    window_o
);
	localparam int FRAME_SIZE = IMG_WIDTH * IMG_HEIGHT;
	localparam int IDX_W      = $clog2(FRAME_SIZE);
	localparam int K          = 3;  // Kernel edge

	cnn_accel_pkg::pixel_t                           img_mem [FRAME_SIZE];
	cnn_accel_pkg::pixel_t [0:cnn_accel_pkg::N_TAPS-1] taps_d;
	cnn_accel_pkg::pixel_t [0:cnn_accel_pkg::N_TAPS-1] taps_q;
	logic                                            vld_q;
	logic                                            first_row;
	logic                                            last_row;
	logic                                            first_col;
	logic                                            last_col;

	// Image buffer, writes outside the frame are dropped
	always_ff @(posedge HCLK) begin
		if (pix_wr_i.we && (pix_wr_i.idx < FRAME_SIZE)) begin
			img_mem[pix_wr_i.idx[IDX_W-1:0]] <= pix_wr_i.data;
		end
	end

	// Boundary flags against the configured size
	assign first_row = (row_i == '0);
	assign last_row  = (row_i == cfg_i.height - 1'b1);
	assign first_col = (col_i == '0);
	assign last_col  = (col_i == cfg_i.width - 1'b1);

	// ------------------------------
	// Zero-padded 3x3 taps
	// ------------------------------
	always_comb begin
		int   addr;
		logic pad;
		for (int dr = 0; dr < K; dr++) begin
			for (int dc = 0; dc < K; dc++) begin
				pad  = (dr == 0 && first_row) || (dr == K-1 && last_row) ||
				       (dc == 0 && first_col) || (dc == K-1 && last_col);
				addr = (int'(row_i) + dr - 1) * IMG_WIDTH + int'(col_i) + dc - 1;  // Fixed stride
				if (pad || addr < 0 || addr >= FRAME_SIZE) taps_d[dr*K+dc] = '0;
				else taps_d[dr*K+dc] = img_mem[addr];
			end
		end
	end

	always_ff @(posedge HCLK) begin
		taps_q <= taps_d;
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) vld_q <= 1'b0;
		else vld_q <= data_run_i;  // Window one cycle behind the scan
	end

	assign window_o = '{valid: vld_q, taps: taps_q};

endmodule

//--- logic/frame_scan_ctrl.sv
`timescale 1ns/10ps
module frame_scan_ctrl (
	input  logic                      HCLK,
	input  logic                      HRESETn,
	input  logic                      start_i,
	input  cnn_accel_pkg::layer_cfg_t cfg_i,
	output logic                      data_run_o,
	output cnn_accel_pkg::dim_t       row_o,
	output cnn_accel_pkg::dim_t       col_o,
	output logic                      frame_done_o
);
	localparam int DRAIN_CYC = 5;  // Window register plus four channel stages

	cnn_accel_pkg::scan_state_t state_q;
	cnn_accel_pkg::delay_t      dly_cnt_q;
	cnn_accel_pkg::delay_t      dly_tgt;
	cnn_accel_pkg::dim_t        row_q;
	cnn_accel_pkg::dim_t        col_q;
	logic                       wait_over;
	logic                       last_col;
	logic                       last_row;
	logic                       last_pix;
	logic [DRAIN_CYC-1:0]       drain_q;  // Last pixel travelling down the pipeline

	assign dly_tgt   = (state_q == cnn_accel_pkg::VSYNC) ? cfg_i.startup_dly : cfg_i.row_dly;
	assign wait_over = ({1'b0, dly_cnt_q} + 13'd1) >= {1'b0, dly_tgt};  // Zero delay still 1 cycle
	assign last_col  = (col_q == cfg_i.width - 1'b1);
	assign last_row  = (row_q == cfg_i.height - 1'b1);
	assign last_pix  = (state_q == cnn_accel_pkg::DATA) && last_col && last_row;

	// ------------------------------
	// Scan FSM
	// ------------------------------
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			state_q   <= cnn_accel_pkg::IDLE;
			dly_cnt_q <= '0;
			row_q     <= '0;
			col_q     <= '0;
		end else begin
			case (state_q)
				cnn_accel_pkg::IDLE: begin
					if (start_i && (drain_q == '0)) begin  // Busy until outputs drained
						state_q   <= cnn_accel_pkg::VSYNC;
						dly_cnt_q <= '0;
						row_q     <= '0;
						col_q     <= '0;
					end
				end
				cnn_accel_pkg::VSYNC: begin
					dly_cnt_q <= wait_over ? '0 : dly_cnt_q + 1'b1;
					if (wait_over) state_q <= cnn_accel_pkg::HSYNC;
				end
				cnn_accel_pkg::HSYNC: begin
					dly_cnt_q <= wait_over ? '0 : dly_cnt_q + 1'b1;
					if (wait_over) state_q <= cnn_accel_pkg::DATA;
				end
				cnn_accel_pkg::DATA: begin
					if (last_col) begin
						col_q <= '0;
						if (last_row) begin
							state_q <= cnn_accel_pkg::IDLE;
						end else begin
							row_q   <= row_q + 1'b1;
							state_q <= cnn_accel_pkg::HSYNC;  // Row delay before next row
						end
					end else begin
						col_q <= col_q + 1'b1;
					end
				end
				default: state_q <= cnn_accel_pkg::IDLE;
			endcase
		end
	end

	// Frame end reported once the last window has left the channels
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) drain_q <= '0;
		else drain_q <= {drain_q[DRAIN_CYC-2:0], last_pix};
	end

	assign data_run_o   = (state_q == cnn_accel_pkg::DATA);
	assign row_o        = row_q;
	assign col_o        = col_q;
	assign frame_done_o = drain_q[DRAIN_CYC-1];

endmodule

//--- logic/ahb_cfg_regs.sv
`timescale 1ns/10ps
module ahb_cfg_regs #(
	parameter int IMG_WIDTH  = 4,
	parameter int IMG_HEIGHT = 4
) (
	input  logic                      HCLK,
	input  logic                      HRESETn,
	input  logic                      hsel_i,
	input  logic                      hready_i,
	input  cnn_accel_pkg::htrans_t    htrans_i,
	input  logic                      hwrite_i,
	input  cnn_accel_pkg::ahb_addr_t  haddr_i,
	input  cnn_accel_pkg::ahb_data_t  hwdata_i,
	output logic                      hready_o,
	output logic                      hresp_o,
	output cnn_accel_pkg::ahb_data_t  hrdata_o,
	input  logic                      frame_done_i,
	output cnn_accel_pkg::layer_cfg_t cfg_o,
	output cnn_accel_pkg::pix_wr_t    pix_wr_o,
	output logic                      start_o
);
	localparam int SEL_LSB = 2;  // Word addressed
	localparam int SEL_MSB = SEL_LSB + $bits(cnn_accel_pkg::reg_sel_t) - 1;
	localparam int PIX_LSB = SEL_MSB + 1;
	localparam int PIX_MSB = PIX_LSB + $bits(cnn_accel_pkg::pix_idx_t) - 1;

	cnn_accel_pkg::reg_sel_t   sel_q;      // Registered in address phase
	logic                      wr_q;
	cnn_accel_pkg::pix_idx_t   pix_idx_q;
	cnn_accel_pkg::layer_cfg_t cfg_q;
	logic                      start_q;
	logic                      done_q;
	logic                      xfer;

	assign xfer = hsel_i && hready_i &&
		((htrans_i == cnn_accel_pkg::TRANS_NONSEQ) || (htrans_i == cnn_accel_pkg::TRANS_SEQ));

	// ------------------------------
	// Address phase
	// ------------------------------
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			sel_q <= '0;
			wr_q  <= 1'b0;
		end else if (xfer) begin
			sel_q <= haddr_i[SEL_MSB:SEL_LSB];
			wr_q  <= hwrite_i;
		end else begin
			wr_q  <= 1'b0;  // IDLE/BUSY or not selected
		end
	end

	always_ff @(posedge HCLK) begin
		if (xfer) pix_idx_q <= haddr_i[PIX_MSB:PIX_LSB];
	end

	// ------------------------------
	// Data phase writes
	// ------------------------------
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			cfg_q.width       <= cnn_accel_pkg::dim_t'(IMG_WIDTH);
			cfg_q.height      <= cnn_accel_pkg::dim_t'(IMG_HEIGHT);
			cfg_q.startup_dly <= 12'd200;
			cfg_q.row_dly     <= 12'd160;
			cfg_q.act_type    <= 1'b0;   // ReLU
			cfg_q.bias_shift  <= 5'd9;
			cfg_q.act_shift   <= 3'd7;
			start_q           <= 1'b0;
		end else begin
			start_q <= 1'b0;  // One-cycle strobe
			if (wr_q) begin
				case (sel_q)
					cnn_accel_pkg::REG_WIDTH_HEIGHT: begin
						cfg_q.width  <= hwdata_i[11:0];
						cfg_q.height <= hwdata_i[27:16];
					end
					cnn_accel_pkg::REG_DELAY_PARAMS: begin
						cfg_q.startup_dly <= hwdata_i[11:0];
						cfg_q.row_dly     <= hwdata_i[23:12];
					end
					cnn_accel_pkg::REG_LAYER_CONFIG: begin
						cfg_q.act_type   <= hwdata_i[3];
						cfg_q.bias_shift <= hwdata_i[12:8];
						cfg_q.act_shift  <= hwdata_i[15:13];
					end
					cnn_accel_pkg::REG_LAYER_START: start_q <= hwdata_i[0];
					default: ;
				endcase
			end
		end
	end

	// Done flag, frame end wins over a start in the same cycle
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) done_q <= 1'b0;
		else if (frame_done_i) done_q <= 1'b1;
		else if (start_q) done_q <= 1'b0;
	end

	// Pixel store lands in the buffer at the end of the data phase
	assign pix_wr_o = '{
		we:   wr_q && (sel_q == cnn_accel_pkg::REG_INPUT_IMAGE),
		idx:  pix_idx_q,
		data: hwdata_i[7:0]
	};
	assign cfg_o    = cfg_q;
	assign start_o  = start_q;
	assign hready_o = 1'b1;  // Zero wait states
	assign hresp_o  = cnn_accel_pkg::RESP_OKAY;

	// ------------------------------
	// Read-back mux
	// ------------------------------
	always_comb begin
		case (sel_q)
			cnn_accel_pkg::REG_WIDTH_HEIGHT:
				hrdata_o = {4'b0, cfg_q.height, 4'b0, cfg_q.width};
			cnn_accel_pkg::REG_DELAY_PARAMS:
				hrdata_o = {8'b0, cfg_q.row_dly, cfg_q.startup_dly};
			cnn_accel_pkg::REG_LAYER_CONFIG:
				hrdata_o = {16'b0, cfg_q.act_shift, cfg_q.bias_shift, 4'b0, cfg_q.act_type, 3'b0};
			cnn_accel_pkg::REG_LAYER_DONE:
				hrdata_o = {31'b0, done_q};
			default: hrdata_o = '0;
		endcase
	end

endmodule

//--- logic/cnn_accel_pkg.sv
package cnn_accel_pkg;

	// ------------------------------
	// Widths and types
	// ------------------------------
	typedef logic [7:0]         pixel_t;    // Unsigned input pixel
	typedef logic signed [7:0]  weight_t;
	typedef logic [7:0]         act_t;      // ReLU byte or signed linear byte
	typedef logic signed [15:0] param_t;    // Scale or bias
	typedef logic signed [21:0] acc_t;      // 2*9 bits plus 4 guard bits
	typedef logic [11:0]        dim_t;
	typedef logic [11:0]        delay_t;
	typedef logic [15:0]        pix_idx_t;  // Linear index into image buffer
	typedef logic [31:0]        ahb_addr_t;
	typedef logic [31:0]        ahb_data_t;
	typedef logic [1:0]         htrans_t;
	typedef logic [2:0]         reg_sel_t;

	localparam int N_CH   = 4;
	localparam int N_TAPS = 9;

	localparam htrans_t TRANS_NONSEQ = 2'b10;
	localparam htrans_t TRANS_SEQ    = 2'b11;
	localparam logic    RESP_OKAY    = 1'b0;

	// Register map, word index in HADDR[4:2]
	localparam reg_sel_t REG_WIDTH_HEIGHT = 3'd0;
	localparam reg_sel_t REG_DELAY_PARAMS = 3'd1;
	localparam reg_sel_t REG_LAYER_CONFIG = 3'd2;
	localparam reg_sel_t REG_INPUT_IMAGE  = 3'd3;  // Pixel index above select bits
	localparam reg_sel_t REG_LAYER_START  = 3'd4;
	localparam reg_sel_t REG_LAYER_DONE   = 3'd5;  // Read only

	typedef enum logic [1:0] {IDLE, VSYNC, HSYNC, DATA} scan_state_t;

	typedef weight_t [0:N_TAPS-1] kernel_t;  // Tap 0 is top-left, row-major

	typedef struct packed {
		logic                 valid;
		pixel_t [0:N_TAPS-1]  taps;
	} window_t;

	typedef struct packed {
		dim_t       width;
		dim_t       height;
		delay_t     startup_dly;
		delay_t     row_dly;
		logic       act_type;    // 0 ReLU, 1 linear
		logic [4:0] bias_shift;
		logic [2:0] act_shift;
	} layer_cfg_t;

	typedef struct packed {
		logic     we;
		pix_idx_t idx;
		pixel_t   data;
	} pix_wr_t;

	// ------------------------------
	// First-layer coefficients
	// ------------------------------
	localparam kernel_t CH_WEIGHTS [N_CH] = '{
		'{-114, -105,  -41,  127,  -93,  -51,  -27,   -1,  113},
		'{  69,  -75,  -47,   19, -128,   95,  -35,  121,    8},
		'{  13,  -12,   -1,  -15,  127,  -16,   -4,  -19,    1},
		'{  69, -121,  -21, -128,   32,   90,   48,   52,  -45}
	};
	localparam param_t CH_SCALE [N_CH] = '{16'sd95, 16'sd103, 16'sd364, 16'sd170};
	localparam param_t CH_BIAS  [N_CH] = '{-16'sd18620, 16'sd8066, 16'sd370, -16'sd506};

endpackage
